// ==== rtl/pipe_trace_pkg.sv ====
package pipe_trace_pkg;

    // Field widths of the timing records
    localparam int TAG_W   = 8;
    localparam int CYCLE_W = 16;
    localparam int HOLD_W  = 4;

    localparam int NUM_STAGES = 5;

    // Pipeline positions, also used as slot array index
    typedef enum logic [2:0] {
        STAGE_FETCH     = 3'd0,
        STAGE_DECODE    = 3'd1,
        STAGE_EXECUTE   = 3'd2,
        STAGE_MEMORY    = 3'd3,
        STAGE_WRITEBACK = 3'd4
    } stage_t;

    // One occupied stage, 29 bits
    typedef struct packed {
        logic               valid;
        logic [TAG_W-1:0]   tag;
        logic [CYCLE_W-1:0] issue_cycle;
        logic [HOLD_W-1:0]  hold;
    } slot_t;

    // Record sent out when an instruction retires, 44 bits
    typedef struct packed {
        logic [TAG_W-1:0]   tag;
        logic [CYCLE_W-1:0] issue_cycle;
        logic [CYCLE_W-1:0] retire_cycle;
        logic [HOLD_W-1:0]  hold;
    } retire_rec_t;

endpackage

// ==== rtl/pipe_cfg_pkg.sv ====
package pipe_cfg_pkg;

    localparam int CFG_DATA_W = 16;

    // Register map, also the opcode of an access
    typedef enum logic [2:0] {
        CFG_CTRL      = 3'd0,
        CFG_TAG_MASK  = 3'd1,
        CFG_TAG_MATCH = 3'd2,
        CFG_RETIRED   = 3'd3,
        CFG_HOLDS     = 3'd4
    } cfg_addr_t;

    // Trace settings toward the retire log, 17 bits
    typedef struct packed {
        logic                             enable;
        logic [pipe_trace_pkg::TAG_W-1:0] tag_mask;
        logic [pipe_trace_pkg::TAG_W-1:0] tag_match;
    } trace_cfg_t;

    // Running totals back from the retire log, 32 bits
    typedef struct packed {
        logic [CFG_DATA_W-1:0] retired;
        logic [CFG_DATA_W-1:0] holds;
    } trace_stat_t;

endpackage

// ==== rtl/pipe_stage_tracker.sv ====
`timescale 1ns/10ps

module pipe_stage_tracker #(
    parameter int MAX_INFLIGHT = 5
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 issue_valid,
    input  logic [pipe_trace_pkg::TAG_W-1:0]     issue_tag,
    input  logic                                 stall,
    output logic                                 issue_ready,
    output pipe_trace_pkg::slot_t                wb_slot,
    output logic [pipe_trace_pkg::CYCLE_W-1:0]   cycle,
    output logic [2:0]                           hold_inc
);

    // One slot per stage, indexed by stage_t
    pipe_trace_pkg::slot_t slot_q [pipe_trace_pkg::NUM_STAGES];
    pipe_trace_pkg::slot_t new_slot;

    logic [pipe_trace_pkg::CYCLE_W-1:0] cycle_q;
    logic [2:0]                         occupied;
    logic                               accept;

    // Held slot gains one hold cycle, saturating
    function automatic pipe_trace_pkg::slot_t hold_slot(input pipe_trace_pkg::slot_t s);
        pipe_trace_pkg::slot_t r;
        r = s;
        if (s.valid && s.hold != '1) begin
            r.hold = s.hold + 1'b1;
        end
        return r;
    endfunction

    always_comb begin
        occupied = '0;
        for (int i = 0; i < pipe_trace_pkg::NUM_STAGES; i++) begin
            occupied = occupied + 3'(slot_q[i].valid);
        end
    end

    // No issue while stalled or at the in-flight limit
    assign issue_ready = !rst && !stall && (int'(occupied) < MAX_INFLIGHT);
    assign accept      = issue_valid && issue_ready;

    // Issue stamp is the cycle of acceptance
    assign new_slot = '{
        valid:       1'b1,
        tag:         issue_tag,
        issue_cycle: cycle_q,
        hold:        '0
    };

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < pipe_trace_pkg::NUM_STAGES; i++) begin
                slot_q[i].valid <= 1'b0;
            end
        end else begin
            if (stall) begin
                // Fetch and decode stay put, bubble into execute
                slot_q[pipe_trace_pkg::STAGE_FETCH]   <=
                    hold_slot(slot_q[pipe_trace_pkg::STAGE_FETCH]);
                slot_q[pipe_trace_pkg::STAGE_DECODE]  <=
                    hold_slot(slot_q[pipe_trace_pkg::STAGE_DECODE]);
                slot_q[pipe_trace_pkg::STAGE_EXECUTE] <= '0;
            end else begin
                slot_q[pipe_trace_pkg::STAGE_FETCH]   <= accept ? new_slot : '0;
                slot_q[pipe_trace_pkg::STAGE_DECODE]  <= slot_q[pipe_trace_pkg::STAGE_FETCH];
                slot_q[pipe_trace_pkg::STAGE_EXECUTE] <= slot_q[pipe_trace_pkg::STAGE_DECODE];
            end
            // Back end always advances
            slot_q[pipe_trace_pkg::STAGE_MEMORY]    <= slot_q[pipe_trace_pkg::STAGE_EXECUTE];
            slot_q[pipe_trace_pkg::STAGE_WRITEBACK] <= slot_q[pipe_trace_pkg::STAGE_MEMORY];
        end
    end

    // Free-running cycle counter, wraps
    always_ff @(posedge clk) begin
        if (rst) begin
            cycle_q <= '0;
        end else begin
            cycle_q <= cycle_q + 1'b1;
        end
    end

    // Valid slots held by this cycle's stall
    assign hold_inc = stall ? 3'(slot_q[pipe_trace_pkg::STAGE_FETCH].valid)
                            + 3'(slot_q[pipe_trace_pkg::STAGE_DECODE].valid)
                            : 3'd0;

    assign wb_slot = slot_q[pipe_trace_pkg::STAGE_WRITEBACK];
    assign cycle   = cycle_q;

endmodule

// ==== rtl/pipe_trace_regs.sv ====
`timescale 1ns/10ps

module pipe_trace_regs (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                cfg_we,
    input  logic                                cfg_re,
    input  pipe_cfg_pkg::cfg_addr_t             cfg_addr,
    input  logic [pipe_cfg_pkg::CFG_DATA_W-1:0] cfg_wdata,
    output logic [pipe_cfg_pkg::CFG_DATA_W-1:0] cfg_rdata,
    output pipe_cfg_pkg::trace_cfg_t            trace_cfg,
    input  pipe_cfg_pkg::trace_stat_t           trace_stat
);

    pipe_cfg_pkg::trace_cfg_t            cfg_q;
    logic [pipe_cfg_pkg::CFG_DATA_W-1:0] rdata_q;

    // Default lets every record through
    always_ff @(posedge clk) begin
        if (rst) begin
            cfg_q <= '{enable: 1'b1, tag_mask: '0, tag_match: '0};
        end else if (cfg_we) begin
            case (cfg_addr)
                pipe_cfg_pkg::CFG_CTRL:      cfg_q.enable    <= cfg_wdata[0];
                pipe_cfg_pkg::CFG_TAG_MASK:  cfg_q.tag_mask  <= cfg_wdata[pipe_trace_pkg::TAG_W-1:0];
                pipe_cfg_pkg::CFG_TAG_MATCH: cfg_q.tag_match <= cfg_wdata[pipe_trace_pkg::TAG_W-1:0];
                // Status counters are read only
                default: ;
            endcase
        end
    end

    // Read data lands one cycle after the strobe and then holds
    always_ff @(posedge clk) begin
        if (rst) begin
            rdata_q <= '0;
        end else if (cfg_re) begin
            case (cfg_addr)
                pipe_cfg_pkg::CFG_CTRL:      rdata_q <= pipe_cfg_pkg::CFG_DATA_W'(cfg_q.enable);
                pipe_cfg_pkg::CFG_TAG_MASK:  rdata_q <= pipe_cfg_pkg::CFG_DATA_W'(cfg_q.tag_mask);
                pipe_cfg_pkg::CFG_TAG_MATCH: rdata_q <= pipe_cfg_pkg::CFG_DATA_W'(cfg_q.tag_match);
                pipe_cfg_pkg::CFG_RETIRED:   rdata_q <= trace_stat.retired;
                pipe_cfg_pkg::CFG_HOLDS:     rdata_q <= trace_stat.holds;
                default:                     rdata_q <= '0;
            endcase
        end
    end

    assign cfg_rdata = rdata_q;
    assign trace_cfg = cfg_q;

endmodule

// ==== rtl/pipe_retire_log.sv ====
`timescale 1ns/10ps

module pipe_retire_log (
    input  logic                                 clk,
    input  logic                                 rst,
    input  pipe_trace_pkg::slot_t                wb_slot,
    input  logic [pipe_trace_pkg::CYCLE_W-1:0]   cycle,
    input  logic [2:0]                           hold_inc,
    input  pipe_cfg_pkg::trace_cfg_t             trace_cfg,
    output logic                                 retire_valid,
    output pipe_trace_pkg::retire_rec_t          retire_rec,
    output pipe_cfg_pkg::trace_stat_t            trace_stat
);

    logic                                retire_valid_q;
    pipe_trace_pkg::retire_rec_t         rec_q;
    logic [pipe_cfg_pkg::CFG_DATA_W-1:0] retired_q;
    logic [pipe_cfg_pkg::CFG_DATA_W-1:0] holds_q;
    logic                                tag_hit;
    logic                                emit;

    // Masked tag must equal the match value
    assign tag_hit = (wb_slot.tag & trace_cfg.tag_mask) == trace_cfg.tag_match;
    assign emit    = wb_slot.valid && trace_cfg.enable && tag_hit;

    always_ff @(posedge clk) begin
        if (rst) begin
            retire_valid_q <= 1'b0;
        end else begin
            retire_valid_q <= emit;
        end
    end

    // Retire stamp is the cycle spent in writeback
    always_ff @(posedge clk) begin
        rec_q <= '{
            tag:          wb_slot.tag,
            issue_cycle:  wb_slot.issue_cycle,
            retire_cycle: cycle,
            hold:         wb_slot.hold
        };
    end

    // Both totals wrap at 16 bits
    always_ff @(posedge clk) begin
        if (rst) begin
            retired_q <= '0;
            holds_q   <= '0;
        end else begin
            retired_q <= retired_q + pipe_cfg_pkg::CFG_DATA_W'(emit);
            // Held slots count whether traced or not
            holds_q   <= holds_q + pipe_cfg_pkg::CFG_DATA_W'(hold_inc);
        end
    end

    assign retire_valid = retire_valid_q;
    assign retire_rec   = rec_q;
    assign trace_stat   = '{retired: retired_q, holds: holds_q};

endmodule

// ==== rtl/pipe_trace_top.sv ====
`timescale 1ns/10ps

module pipe_trace_top #(
    parameter int MAX_INFLIGHT = 5
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                issue_valid,
    input  logic [pipe_trace_pkg::TAG_W-1:0]    issue_tag,
    input  logic                                stall,
    output logic                                issue_ready,
    input  logic                                cfg_we,
    input  logic                                cfg_re,
    input  pipe_cfg_pkg::cfg_addr_t             cfg_addr,
    input  logic [pipe_cfg_pkg::CFG_DATA_W-1:0] cfg_wdata,
    output logic [pipe_cfg_pkg::CFG_DATA_W-1:0] cfg_rdata,
    output logic                                retire_valid,
    output pipe_trace_pkg::retire_rec_t         retire_rec
);

    pipe_trace_pkg::slot_t              wb_slot;
    logic [pipe_trace_pkg::CYCLE_W-1:0] cycle;
    logic [2:0]                         hold_inc;
    pipe_cfg_pkg::trace_cfg_t           trace_cfg;
    pipe_cfg_pkg::trace_stat_t          trace_stat;

    pipe_stage_tracker #(
        .MAX_INFLIGHT(MAX_INFLIGHT)
    ) pipe_stage_tracker_inst (
        .clk(clk), .rst(rst),
        .issue_valid(issue_valid), .issue_tag(issue_tag), .stall(stall),
        .issue_ready(issue_ready),
        .wb_slot(wb_slot), .cycle(cycle), .hold_inc(hold_inc)
    );

    pipe_trace_regs pipe_trace_regs_inst (
        .clk(clk), .rst(rst),
        .cfg_we(cfg_we), .cfg_re(cfg_re), .cfg_addr(cfg_addr),
        .cfg_wdata(cfg_wdata), .cfg_rdata(cfg_rdata),
        .trace_cfg(trace_cfg), .trace_stat(trace_stat)
    );

    pipe_retire_log pipe_retire_log_inst (
        .clk(clk), .rst(rst),
        .wb_slot(wb_slot), .cycle(cycle), .hold_inc(hold_inc),
        .trace_cfg(trace_cfg),
        .retire_valid(retire_valid), .retire_rec(retire_rec),
        .trace_stat(trace_stat)
    );

endmodule

// ==== bench/pipe_trace_assert.sv ====
`timescale 1ns/10ps

module pipe_trace_assert (
    input logic                  clk,
    input logic                  rst,
    input logic                  stall,
    input logic                  issue_ready,
    input pipe_trace_pkg::slot_t fetch_slot,
    input pipe_trace_pkg::slot_t decode_slot,
    input pipe_trace_pkg::slot_t wb_slot
);

    stall_blocks_issue: assert property (@(posedge clk) disable iff (rst)
        stall |-> !issue_ready)
        else $error("issue_ready is high while stall is high");

    fetch_keeps_tag: assert property (@(posedge clk) disable iff (rst)
        (stall && fetch_slot.valid) |=> (fetch_slot.valid && fetch_slot.tag == $past(fetch_slot.tag)))
        else $error("held fetch slot lost its tag");

    decode_keeps_tag: assert property (@(posedge clk) disable iff (rst)
        (stall && decode_slot.valid) |=>
            (decode_slot.valid && decode_slot.tag == $past(decode_slot.tag)))
        else $error("held decode slot lost its tag");

    // Each instruction sits one cycle in writeback, so its record pulses once
    wb_single_cycle: assert property (@(posedge clk) disable iff (rst)
        wb_slot.valid |=> !(wb_slot.valid && wb_slot.tag == $past(wb_slot.tag)
                            && wb_slot.issue_cycle == $past(wb_slot.issue_cycle)))
        else $error("writeback held the same instruction for two cycles");

endmodule

bind pipe_stage_tracker pipe_trace_assert pipe_trace_assert_inst (
    .clk(clk), .rst(rst), .stall(stall), .issue_ready(issue_ready),
    .fetch_slot(slot_q[pipe_trace_pkg::STAGE_FETCH]),
    .decode_slot(slot_q[pipe_trace_pkg::STAGE_DECODE]),
    .wb_slot(wb_slot)
);

// ==== bench/pipe_trace_checker.sv ====
`timescale 1ns/10ps

module pipe_trace_checker #(
    parameter int MAX_INFLIGHT = 5
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                issue_valid,
    input  logic [pipe_trace_pkg::TAG_W-1:0]    issue_tag,
    input  logic                                stall,
    input  logic                                issue_ready,
    input  logic                                cfg_we,
    input  logic                                cfg_re,
    input  pipe_cfg_pkg::cfg_addr_t             cfg_addr,
    input  logic [pipe_cfg_pkg::CFG_DATA_W-1:0] cfg_wdata,
    input  logic [pipe_cfg_pkg::CFG_DATA_W-1:0] cfg_rdata,
    input  logic [pipe_cfg_pkg::CFG_DATA_W-1:0] exp_rdata,
    input  logic                                retire_valid,
    input  pipe_trace_pkg::retire_rec_t         retire_rec,
    output int                                  error_count,
    output int                                  records,
    output int                                  reads
);

    // Model slots, index 0 is fetch and 4 is writeback
    pipe_trace_pkg::slot_t               m_slot [5];
    logic [pipe_trace_pkg::CYCLE_W-1:0]  m_cycle;
    logic                                m_enable;
    logic [pipe_trace_pkg::TAG_W-1:0]    m_mask;
    logic [pipe_trace_pkg::TAG_W-1:0]    m_match;
    logic                                exp_valid;
    pipe_trace_pkg::retire_rec_t         exp_rec;
    logic                                read_pending;
    logic [pipe_cfg_pkg::CFG_DATA_W-1:0] read_exp;
    logic                                exp_ready;
    int                                  occupied;
    int                                  errs = 0;
    int                                  rec_count = 0;
    int                                  read_count = 0;

    task automatic flag_mismatch(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
        errs = errs + 1;
        $display("Error at %0t: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
    endtask

    // DUT outputs read here still hold the values of the cycle now ending
    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 5; i++) begin
                m_slot[i] = '0;
            end
            m_cycle      = '0;
            m_enable     = 1'b1;
            m_mask       = '0;
            m_match      = '0;
            exp_valid    = 1'b0;
            read_pending = 1'b0;
            if (issue_ready !== 1'b0) begin
                flag_mismatch("issue_ready", 64'(1'b0), 64'(issue_ready));
            end
        end else begin
            occupied = 0;
            for (int i = 0; i < 5; i++) begin
                occupied = occupied + int'(m_slot[i].valid);
            end
            exp_ready = !stall && (occupied < MAX_INFLIGHT);
            if (issue_ready !== exp_ready) begin
                flag_mismatch("issue_ready", 64'(exp_ready), 64'(issue_ready));
            end
            if (retire_valid !== exp_valid) begin
                flag_mismatch("retire_valid", 64'(exp_valid), 64'(retire_valid));
            end else if (exp_valid) begin
                rec_count = rec_count + 1;
                if (retire_rec !== exp_rec) begin
                    flag_mismatch("retire_rec", 64'(exp_rec), 64'(retire_rec));
                end
            end
            if (read_pending) begin
                read_count = read_count + 1;
                if (cfg_rdata !== read_exp) begin
                    flag_mismatch("cfg_rdata", 64'(read_exp), 64'(cfg_rdata));
                end
            end
            read_pending = cfg_re;
            read_exp     = exp_rdata;

            // Record for the writeback occupant, shown next cycle
            exp_valid = m_slot[4].valid && m_enable && ((m_slot[4].tag & m_mask) == m_match);
            exp_rec   = '{tag: m_slot[4].tag, issue_cycle: m_slot[4].issue_cycle,
                          retire_cycle: m_cycle, hold: m_slot[4].hold};
            m_slot[4] = m_slot[3];
            m_slot[3] = m_slot[2];
            if (stall) begin
                m_slot[2] = '0;
                for (int i = 0; i < 2; i++) begin
                    if (m_slot[i].valid && m_slot[i].hold < 4'd15) begin
                        m_slot[i].hold = m_slot[i].hold + 4'd1;
                    end
                end
            end else begin
                m_slot[2] = m_slot[1];
                m_slot[1] = m_slot[0];
                m_slot[0] = '0;
                if (issue_valid && exp_ready) begin
                    m_slot[0] = '{valid: 1'b1, tag: issue_tag, issue_cycle: m_cycle, hold: '0};
                end
            end

            if (cfg_we) begin
                case (cfg_addr)
                    pipe_cfg_pkg::CFG_CTRL:      m_enable = cfg_wdata[0];
                    pipe_cfg_pkg::CFG_TAG_MASK:  m_mask = cfg_wdata[pipe_trace_pkg::TAG_W-1:0];
                    pipe_cfg_pkg::CFG_TAG_MATCH: m_match = cfg_wdata[pipe_trace_pkg::TAG_W-1:0];
                    default: ;
                endcase
            end
            m_cycle = m_cycle + 16'd1;
        end
    end

    assign error_count = errs;
    assign records     = rec_count;
    assign reads       = read_count;

endmodule

// ==== bench/pipe_trace_tb.sv ====
`timescale 1ns/10ps

module pipe_trace_tb;

    localparam int    MAX_INFLIGHT = 5;
    localparam int    NUM_ROWS     = 25;
    localparam int    NUM_COLS     = 8;
    localparam int    RESET_CYCLES = 10;
    localparam int    TAIL_CYCLES  = 8;
    localparam int    CLK_PERIOD   = 10;
    localparam string DATA_FILE    = "bench/pipe_trace_input.txt";

    logic                                clk;
    logic                                rst;
    logic                                issue_valid;
    logic [pipe_trace_pkg::TAG_W-1:0]    issue_tag;
    logic                                stall;
    logic                                issue_ready;
    logic                                cfg_we;
    logic                                cfg_re;
    pipe_cfg_pkg::cfg_addr_t             cfg_addr;
    logic [pipe_cfg_pkg::CFG_DATA_W-1:0] cfg_wdata;
    logic [pipe_cfg_pkg::CFG_DATA_W-1:0] cfg_rdata;
    logic [pipe_cfg_pkg::CFG_DATA_W-1:0] exp_rdata;
    logic                                retire_valid;
    pipe_trace_pkg::retire_rec_t         retire_rec;
    logic [15:0]                         rows [NUM_ROWS*NUM_COLS];
    int                                  error_count;
    int                                  records;
    int                                  reads;

    pipe_trace_top #(.MAX_INFLIGHT(MAX_INFLIGHT)) pipe_trace_top_inst (.*);

    pipe_trace_checker #(.MAX_INFLIGHT(MAX_INFLIGHT)) pipe_trace_checker_inst (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    task automatic drive_idle();
        issue_valid = 1'b0;
        issue_tag   = '0;
        stall       = 1'b0;
        cfg_we      = 1'b0;
        cfg_re      = 1'b0;
        cfg_addr    = pipe_cfg_pkg::CFG_CTRL;
        cfg_wdata   = '0;
        exp_rdata   = '0;
    endtask

    // Columns are valid, tag, stall, we, re, addr, wdata, expected read
    task automatic drive_row(input int r);
        int base;
        base        = r * NUM_COLS;
        issue_valid = rows[base][0];
        issue_tag   = rows[base+1][pipe_trace_pkg::TAG_W-1:0];
        stall       = rows[base+2][0];
        cfg_we      = rows[base+3][0];
        cfg_re      = rows[base+4][0];
        cfg_addr    = pipe_cfg_pkg::cfg_addr_t'(rows[base+5][2:0]);
        cfg_wdata   = rows[base+6];
        exp_rdata   = rows[base+7];
    endtask

    // Run limit of 20 cycles per data row plus reset
    initial begin
        #((RESET_CYCLES + 20 * NUM_ROWS) * CLK_PERIOD);
        $display("Timeout: run did not end within %0d cycles", RESET_CYCLES + 20 * NUM_ROWS);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        rst = 1'b1;
        drive_idle();
        for (int i = 0; i < NUM_ROWS * NUM_COLS; i++) begin
            rows[i] = ~16'(i);
        end
        $readmemh(DATA_FILE, rows);
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        if (rows[NUM_ROWS*NUM_COLS-1] == ~16'(NUM_ROWS * NUM_COLS - 1)) begin
            $display("Stimulus file %s is missing or has too few rows", DATA_FILE);
            $display("TESTBENCH FAILED");
        end else begin
            for (int r = 0; r < NUM_ROWS; r++) begin
                drive_row(r);
                @(negedge clk);
            end
            // Pipeline drains and the last read lands
            drive_idle();
            repeat (TAIL_CYCLES) @(negedge clk);
            $display("Done: %0d records and %0d reads checked, %0d errors",
                     records, reads, error_count);
            if (error_count == 0) begin
                $display("TESTBENCH PASSED");
            end else begin
                $display("TESTBENCH FAILED");
            end
        end
        $finish;
    end

endmodule

// ==== bench/pipe_trace_input.txt ====
// Hex columns: issue_valid tag stall cfg_we cfg_re cfg_addr cfg_wdata expected_read
// Addresses: 0 ctrl, 1 tag mask, 2 tag match, 3 retired total, 4 hold total
1 10 0 0 0 0 0000 0000
1 11 0 0 0 0 0000 0000
1 12 0 0 0 0 0000 0000
1 13 0 0 0 0 0000 0000
1 14 0 0 0 0 0000 0000
1 15 0 0 0 0 0000 0000
1 15 0 0 0 0 0000 0000
1 16 0 0 0 0 0000 0000
1 19 1 0 0 0 0000 0000
0 00 1 0 0 0 0000 0000
1 18 0 0 0 0 0000 0000
0 00 1 0 0 0 0000 0000
0 00 0 0 1 4 0000 0006
0 00 0 0 1 3 0000 0005
0 00 0 1 0 1 000F 0000
0 00 0 1 0 2 0007 0000
1 17 0 0 0 0 0000 0000
1 27 0 0 0 0 0000 0000
1 37 0 0 0 0 0000 0000
0 00 0 1 1 3 FFFF 0006
0 00 0 0 0 0 0000 0000
0 00 0 0 0 0 0000 0000
0 00 0 1 0 0 0000 0000
0 00 0 0 1 4 0000 0006
0 00 0 0 1 3 0000 0008

// ==== sim.f ====
rtl/pipe_trace_pkg.sv
rtl/pipe_cfg_pkg.sv
rtl/pipe_stage_tracker.sv
rtl/pipe_trace_regs.sv
rtl/pipe_retire_log.sv
rtl/pipe_trace_top.sv
bench/pipe_trace_assert.sv
bench/pipe_trace_checker.sv
bench/pipe_trace_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= pipe_trace_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf $(BUILD_DIR)
